// File: Makefile
# Verilator build and run for the pipeline control testbench

VERILATOR ?= verilator
TOP       ?= pipeCtrlTb
FLIST     ?= pipeCtrl.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

check:
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/ctrlFsm.sv
`timescale 1ns/10ps

module ctrlFsm (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                accept,
    input  pipeCtrlPkg::op_e                    inOp,
    input  logic                                excReq,
    input  logic                                timerDone,
    input  logic                                stallAll,
    output pipeCtrlPkg::state_e                 state,
    output logic                                intakeBlock,
    output logic                                holdE,
    output logic                                killEM,
    output logic                                timerLoad,
    output logic [pipeCtrlPkg::TIMER_W-1:0]     timerValue
);
    import pipeCtrlPkg::*;

    state_e stateNext;
    logic   divStart;
    logic   waitOver;

    // exceptions are ignored while already recovering
    assign killEM   = excReq & (state != stRecover);
    assign divStart = accept & (inOp == opDiv);
    assign waitOver = timerDone & ~stallAll;   // last count on a moving cycle

    assign timerLoad  = killEM | divStart;
    assign timerValue = killEM ? TIMER_W'(RECOVER_CYCLES) : TIMER_W'(DIV_CYCLES);

    assign intakeBlock = (state != stRun);
    // release E on the final divide cycle so it leaves on time
    assign holdE = (state == stDivWait) & ~timerDone;

    always_comb begin
        stateNext = state;
        case (state)
            stRun: begin
                if (killEM) begin
                    stateNext = stRecover;
                end else if (divStart) begin
                    stateNext = stDivWait;
                end
            end
            stDivWait: begin
                if (killEM) begin
                    stateNext = stRecover;   // divide is killed with E
                end else if (waitOver) begin
                    stateNext = stRun;
                end
            end
            stRecover: begin
                if (waitOver) begin
                    stateNext = stRun;
                end
            end
            default: stateNext = stRun;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stRun;
        end else begin
            state <= stateNext;
        end
    end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    // decode-stage intake
    input  logic                inValid,
    input  pipeCtrlPkg::regAddr_t inRs,
    input  pipeCtrlPkg::regAddr_t inRt,
    // execute stage
    input  logic                eValid,
    input  pipeCtrlPkg::regAddr_t eRd,
    input  logic                eWrite,
    input  pipeCtrlPkg::op_e    eOp,
    // memory stage
    input  logic                mValid,
    input  pipeCtrlPkg::regAddr_t mRd,
    input  logic                mWrite,
    // writeback stage
    input  logic                wValid,
    input  pipeCtrlPkg::regAddr_t wRd,
    input  logic                wWrite,
    input  logic                retReady,
    // from control FSM
    input  logic                holdE,
    input  logic                intakeBlock,
    output pipeCtrlPkg::fwd_e   fwdRs,
    output pipeCtrlPkg::fwd_e   fwdRt,
    output logic                loadUse,
    output logic                stallAll,
    output logic                advanceE,
    output logic                inReady,
    output logic                accept
);
    import pipeCtrlPkg::*;

    logic eFwdOk;
    logic mFwdOk;
    logic wFwdOk;
    logic eIsLoad;
    logic rsHitE;
    logic rtHitE;

    // only a live stage that writes rd can supply an operand
    assign eFwdOk = eValid & eWrite;
    assign mFwdOk = mValid & mWrite;
    assign wFwdOk = wValid & wWrite;

    // priority E > M > W, r0 never forwarded
    function automatic fwd_e pickFwd(input regAddr_t src);
        fwd_e sel;
        if (src == '0) begin
            sel = fwdNone;
        end else if (eFwdOk && (src == eRd)) begin
            sel = fwdE;
        end else if (mFwdOk && (src == mRd)) begin
            sel = fwdM;
        end else if (wFwdOk && (src == wRd)) begin
            sel = fwdW;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    always_comb begin
        fwdRs = pickFwd(inRs);
        fwdRt = pickFwd(inRt);
    end

    // load data is not ready until M, so an E match must wait a cycle
    assign eIsLoad = eFwdOk & (eOp == opLoad);
    assign rsHitE  = (inRs != '0) & (inRs == eRd);
    assign rtHitE  = (inRt != '0) & (inRt == eRd);
    assign loadUse = inValid & eIsLoad & (rsHitE | rtHitE);

    // retire back-pressure freezes every stage
    assign stallAll = wValid & ~retReady;

    // E moves on unless a divide is still running or the pipe is frozen
    assign advanceE = ~holdE & ~stallAll;

    assign inReady = ~stallAll & ~loadUse & ~intakeBlock;
    assign accept  = inValid & inReady;   // handshake at decode

endmodule

// File: design/pipeCtrlPkg.sv
package pipeCtrlPkg;

    // architectural register number, r0 reads as zero
    typedef logic [4:0] regAddr_t;

    // tag travels with the instruction only for retirement checks
    typedef logic [7:0] tag_t;

    typedef enum logic [1:0] {
        opAlu   = 2'b00,
        opLoad  = 2'b01,
        opStore = 2'b10,   // the only opcode without a destination
        opDiv   = 2'b11    // multicycle, holds execute
    } op_e;

    // operand mux select at decode, E has highest priority
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdW    = 2'b01,
        fwdM    = 2'b10,
        fwdE    = 2'b11
    } fwd_e;

    typedef enum logic [1:0] {
        stRun     = 2'b00,
        stDivWait = 2'b01,
        stRecover = 2'b10
    } state_e;

    localparam int DIV_CYCLES     = 8;   // total cycles a divide sits in E
    localparam int RECOVER_CYCLES = 4;   // intake blocked after exception

    // counter must hold the longer of the two waits
    localparam int MAX_WAIT = (DIV_CYCLES > RECOVER_CYCLES) ? DIV_CYCLES : RECOVER_CYCLES;
    localparam int TIMER_W  = $clog2(MAX_WAIT + 1);

    // rd is written by everything but stores, never r0
    function automatic logic writesRd(input op_e op, input regAddr_t rd);
        return (op != opStore) && (rd != '0);
    endfunction

endpackage

// File: design/pipeCtrlTop.sv
`timescale 1ns/10ps

module pipeCtrlTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    output logic                  inReady,
    input  pipeCtrlPkg::tag_t     inTag,
    input  pipeCtrlPkg::regAddr_t inRs,
    input  pipeCtrlPkg::regAddr_t inRt,
    input  pipeCtrlPkg::regAddr_t inRd,
    input  pipeCtrlPkg::op_e      inOp,
    output pipeCtrlPkg::fwd_e     fwdRs,
    output pipeCtrlPkg::fwd_e     fwdRt,
    input  logic                  excReq,
    output logic                  retValid,
    input  logic                  retReady,
    output pipeCtrlPkg::tag_t     retTag,
    output pipeCtrlPkg::regAddr_t retRd,
    output logic                  retWrite
);
    import pipeCtrlPkg::*;

    // stage fields seen by the hazard logic
    logic     eValid;
    regAddr_t eRd;
    logic     eWrite;
    op_e      eOp;
    logic     mValid;
    regAddr_t mRd;
    logic     mWrite;
    logic     wValid;
    regAddr_t wRd;
    logic     wWrite;

    // pipeline control
    logic               accept;
    logic               stallAll;
    logic               advanceE;
    logic               intakeBlock;
    logic               holdE;
    logic               killEM;
    logic               timerLoad;
    logic [TIMER_W-1:0] timerValue;
    logic               timerDone;

    hazardUnit hazardInst (
        .inValid     (inValid),
        .inRs        (inRs),
        .inRt        (inRt),
        .eValid      (eValid),
        .eRd         (eRd),
        .eWrite      (eWrite),
        .eOp         (eOp),
        .mValid      (mValid),
        .mRd         (mRd),
        .mWrite      (mWrite),
        .wValid      (wValid),
        .wRd         (wRd),
        .wWrite      (wWrite),
        .retReady    (retReady),
        .holdE       (holdE),
        .intakeBlock (intakeBlock),
        .fwdRs       (fwdRs),
        .fwdRt       (fwdRt),
        .loadUse     (),
        .stallAll    (stallAll),
        .advanceE    (advanceE),
        .inReady     (inReady),
        .accept      (accept)
    );

    stageTracker trackerInst (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .inTag    (inTag),
        .inRd     (inRd),
        .inOp     (inOp),
        .advanceE (advanceE),
        .stallAll (stallAll),
        .killEM   (killEM),
        .eValid   (eValid),
        .eRd      (eRd),
        .eWrite   (eWrite),
        .eOp      (eOp),
        .mValid   (mValid),
        .mRd      (mRd),
        .mWrite   (mWrite),
        .wValid   (wValid),
        .wRd      (wRd),
        .wWrite   (wWrite),
        .retValid (retValid),
        .retTag   (retTag),
        .retRd    (retRd),
        .retWrite (retWrite),
        .retReady (retReady)
    );

    ctrlFsm fsmInst (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .inOp        (inOp),
        .excReq      (excReq),
        .timerDone   (timerDone),
        .stallAll    (stallAll),
        .state       (),
        .intakeBlock (intakeBlock),
        .holdE       (holdE),
        .killEM      (killEM),
        .timerLoad   (timerLoad),
        .timerValue  (timerValue)
    );

    stallTimer timerInst (
        .clk   (clk),
        .rst   (rst),
        .load  (timerLoad),
        .value (timerValue),
        .stall (stallAll),
        .done  (timerDone)
    );

endmodule

// File: design/stageTracker.sv
`timescale 1ns/10ps

module stageTracker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  accept,
    input  pipeCtrlPkg::tag_t     inTag,
    input  pipeCtrlPkg::regAddr_t inRd,
    input  pipeCtrlPkg::op_e      inOp,
    input  logic                  advanceE,
    input  logic                  stallAll,
    input  logic                  killEM,
    output logic                  eValid,
    output pipeCtrlPkg::regAddr_t eRd,
    output logic                  eWrite,
    output pipeCtrlPkg::op_e      eOp,
    output logic                  mValid,
    output pipeCtrlPkg::regAddr_t mRd,
    output logic                  mWrite,
    output logic                  wValid,
    output pipeCtrlPkg::regAddr_t wRd,
    output logic                  wWrite,
    output logic                  retValid,
    output pipeCtrlPkg::tag_t     retTag,
    output pipeCtrlPkg::regAddr_t retRd,
    output logic                  retWrite,
    input  logic                  retReady
);
    import pipeCtrlPkg::*;

    tag_t eTag;
    tag_t mTag;
    tag_t wTag;
    logic eToM;     // live entry leaves E this cycle
    logic mToW;     // live entry leaves M this cycle

    assign eToM = eValid & advanceE & ~killEM;
    assign mToW = mValid & ~stallAll & ~killEM;

    // valid bits, the only control state here
    always_ff @(posedge clk) begin
        if (rst) begin
            eValid <= 1'b0;
            mValid <= 1'b0;
            wValid <= 1'b0;
        end else begin
            if (killEM) begin
                eValid <= 1'b0;       // includes anything accepted now
            end else if (advanceE) begin
                eValid <= accept;     // bubble when nothing arrives
            end

            if (killEM) begin
                mValid <= 1'b0;
            end else if (!stallAll) begin
                mValid <= eToM;       // bubble while E is held
            end

            // W keeps its entry through an exception
            if (mToW) begin
                wValid <= 1'b1;
            end else if (wValid && retReady) begin
                wValid <= 1'b0;       // retired with nothing behind it
            end
        end
    end

    // payload follows its valid bit
    always_ff @(posedge clk) begin
        if (accept) begin
            eTag   <= inTag;
            eRd    <= inRd;
            eOp    <= inOp;
            eWrite <= writesRd(inOp, inRd);
        end
        if (eToM && !stallAll) begin
            mTag   <= eTag;
            mRd    <= eRd;
            mWrite <= eWrite;
        end
        if (mToW) begin
            wTag   <= mTag;
            wRd    <= mRd;
            wWrite <= mWrite;
        end
    end

    // retire port is the W stage itself
    assign retValid = wValid;
    assign retTag   = wTag;
    assign retRd    = wRd;
    assign retWrite = wWrite;

endmodule

// File: design/stallTimer.sv
`timescale 1ns/10ps

module stallTimer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic [pipeCtrlPkg::TIMER_W-1:0] value,
    input  logic                            stall,
    output logic                            done
);
    import pipeCtrlPkg::*;

    logic [TIMER_W-1:0] count;   // zero when idle

    // one counter for divide and recovery, they never overlap
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= value;          // load wins over a stall
        end else if (!stall && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // final count of the wait
    assign done = (count == TIMER_W'(1));

endmodule

// File: dv/pipeCtrlTb.sv
`timescale 1ns/10ps

module pipeCtrlTb;
    import pipeCtrlPkg::*;

    localparam int NUM_TESTS = 6;
    localparam int INSTR_PER_TEST = 400;
    localparam int WORST_CPI = 40;   // divide plus recovery plus back-pressure

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     inValid = 1'b0;
    logic     inReady;
    tag_t     inTag = '0;
    regAddr_t inRs = '0;
    regAddr_t inRt = '0;
    regAddr_t inRd = '0;
    op_e      inOp = opAlu;
    fwd_e     fwdRs;
    fwd_e     fwdRt;
    logic     excReq = 1'b0;
    logic     retValid;
    logic     retReady = 1'b1;
    tag_t     retTag;
    regAddr_t retRd;
    logic     retWrite;

    integer seed = 1465;
    int     errors = 0;
    int     testErrors = 0;
    int     checks = 0;
    logic   holdIn = 1'b0;
    tag_t   nextTag = '0;

    // model of the pipe
    logic     eV, mV, wV;
    tag_t     eTag, mTag, wTag;
    regAddr_t eRd, mRd, wRd;
    logic     eW, mW, wW;
    op_e      eOp;
    state_e   st;
    int       cnt;

    pipeCtrlTop dut_i (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .inTag(inTag),
        .inRs(inRs), .inRt(inRt), .inRd(inRd), .inOp(inOp),
        .fwdRs(fwdRs), .fwdRt(fwdRt), .excReq(excReq),
        .retValid(retValid), .retReady(retReady), .retTag(retTag),
        .retRd(retRd), .retWrite(retWrite)
    );

    always #5 clk = ~clk;

    initial begin
        #(NUM_TESTS * INSTR_PER_TEST * WORST_CPI * 10 + 1000);
        $display("watchdog expired, DUT stopped accepting instructions");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic countErr();
        errors++;
        testErrors++;
    endtask

    task automatic checkFwd(string name, fwd_e exp, fwd_e act);
        checks++;
        if (exp !== act) begin
            $display("error t=%0t %s exp=%s act=%s", $time, name, exp.name(), act.name());
            countErr();
        end
    endtask

    task automatic checkTag(string name, tag_t exp, tag_t act);
        checks++;
        if (exp !== act) begin
            $display("error t=%0t %s exp=%0d act=%0d", $time, name, exp, act);
            countErr();
        end
    endtask

    task automatic checkReg(string name, regAddr_t exp, regAddr_t act);
        checks++;
        if (exp !== act) begin
            $display("error t=%0t %s exp=r%0d act=r%0d", $time, name, exp, act);
            countErr();
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            $display("error t=%0t %s exp=%b act=%b", $time, name, exp, act);
            countErr();
        end
    endtask

    // E beats M beats W and r0 never forwards
    function automatic fwd_e chooseFwd(regAddr_t src);
        if (src == 0) return fwdNone;
        if (eV && eW && src == eRd) return fwdE;
        if (mV && mW && src == mRd) return fwdM;
        if (wV && wW && src == wRd) return fwdW;
        return fwdNone;
    endfunction

    function automatic logic oneIn(int n);
        return ($random(seed) % n) == 0;
    endfunction

    task automatic pickInstr(int mode);
        int r;
        r = $random(seed);
        inValid = (mode <= 3) ? !oneIn(8) : !oneIn(4);
        inRs = (mode == 2) ? regAddr_t'(r & 3) : regAddr_t'(r & 7);
        inRt = (mode == 2) ? regAddr_t'((r >> 3) & 3) : regAddr_t'((r >> 3) & 7);
        inRd = (mode == 2) ? regAddr_t'((r >> 6) & 3) : regAddr_t'((r >> 6) & 7);
        case (mode)
            1: inOp = r[9] ? opStore : opAlu;
            2: inOp = r[9] ? opLoad : opAlu;
            3: inOp = (r[10:9] == 2'b11) ? opDiv : opAlu;
            5: inOp = r[9] ? opLoad : opAlu;
            default: inOp = op_e'(r[10:9]);
        endcase
        inTag = nextTag;
        if (inValid) nextTag++;
    endtask

    task automatic runCycle(int mode, inout int accepted);
        logic stall, loadUse, ready, acc, kill, done, holdE, advE, mToW, eToM;
        state_e stNext;
        @(negedge clk);
        if (!holdIn) pickInstr(mode);
        retReady = (mode == 4) ? oneIn(2) : (mode == 6) ? !oneIn(4) : 1'b1;
        excReq = (mode == 5) ? oneIn(8) : (mode == 6) ? oneIn(32) : 1'b0;
        #1;
        stall = wV & ~retReady;
        loadUse = inValid & eV & eW & (eOp == opLoad)
            & (((inRs != 0) && (inRs == eRd)) || ((inRt != 0) && (inRt == eRd)));
        ready = ~stall & ~loadUse & (st == stRun);
        acc = inValid & ready;
        kill = excReq & (st != stRecover);
        done = (cnt == 1);
        holdE = (st == stDivWait) & ~done;
        advE = ~holdE & ~stall;
        checkBit("inReady", ready, inReady);
        if (inValid) begin
            checkFwd("fwdRs", chooseFwd(inRs), fwdRs);
            checkFwd("fwdRt", chooseFwd(inRt), fwdRt);
        end
        checkBit("retValid", wV, retValid);
        if (wV) begin
            checkTag("retTag", wTag, retTag);
            checkReg("retRd", wRd, retRd);
            checkBit("retWrite", wW, retWrite);
        end
        holdIn = inValid & ~acc;
        if (acc) accepted++;
        mToW = mV & ~stall & ~kill;
        eToM = eV & advE & ~kill;
        stNext = st;
        case (st)
            stRun: stNext = kill ? stRecover : (acc && inOp == opDiv) ? stDivWait : stRun;
            stDivWait: stNext = kill ? stRecover : (done && !stall) ? stRun : stDivWait;
            default: stNext = (done && !stall) ? stRun : stRecover;
        endcase
        @(posedge clk);
        if (mToW) begin
            {wV, wTag, wRd, wW} = {1'b1, mTag, mRd, mW};
        end else if (wV && retReady) begin
            wV = 1'b0;
        end
        if (kill) mV = 1'b0;
        else if (!stall) mV = eToM;
        if (eToM) {mTag, mRd, mW} = {eTag, eRd, eW};
        if (kill) eV = 1'b0;
        else if (advE) eV = acc;
        if (acc) begin
            eTag = inTag;
            eRd = inRd;
            eOp = inOp;
            eW = (inOp != opStore) && (inRd != 0);   // stores never write
        end
        if (kill) cnt = RECOVER_CYCLES;
        else if (acc && inOp == opDiv) cnt = DIV_CYCLES;
        else if (!stall && cnt != 0) cnt--;
        st = stNext;
    endtask

    task automatic runTest(int mode, string name);
        int accepted;
        int cycles;
        accepted = 0;
        cycles = 0;
        testErrors = 0;
        while (accepted < INSTR_PER_TEST) begin
            runCycle(mode, accepted);
            cycles++;
        end
        $display("test %0d %s: %0d instructions, %0d cycles, %0d errors",
            mode, name, accepted, cycles, testErrors);
    endtask

    initial begin
        {eV, mV, wV} = 3'b000;
        {eW, mW, wW} = 3'b000;
        {eTag, mTag, wTag} = '0;
        {eRd, mRd, wRd} = '0;
        eOp = opAlu;
        st = stRun;
        cnt = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        runTest(1, "in-order alu/store");
        runTest(2, "load-use");
        runTest(3, "divide");
        runTest(4, "back-pressure");
        runTest(5, "exception");
        runTest(6, "full random");
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: pipeCtrl.f
design/pipeCtrlPkg.sv
design/hazardUnit.sv
design/stageTracker.sv
design/ctrlFsm.sv
design/stallTimer.sv
design/pipeCtrlTop.sv
dv/pipeCtrlTb.sv
